/* include/hififo_settings.svh */
`ifndef HIFIFO_SETTINGS_SVH
`define HIFIFO_SETTINGS_SVH

// value returned from register 0
`define HIFIFO_ID 64'd253

// register word address, taken from DW2 bits 15:3
`define HIFIFO_ADDR_W 13

// external event lines
`define HIFIFO_IRQ_W 4

// register map
`define HIFIFO_REG_ID `HIFIFO_ADDR_W'd0
`define HIFIFO_REG_COUNT `HIFIFO_ADDR_W'd1
`define HIFIFO_REG_STATUS `HIFIFO_ADDR_W'd2
`define HIFIFO_REG_SCRATCH `HIFIFO_ADDR_W'd3
`define HIFIFO_REG_MASK `HIFIFO_ADDR_W'd255

`endif

/* logic/hififo_pkg.sv */
package hififo_pkg;

   // fmt[1:0] and type[4:0] of the supported TLPs
   typedef enum logic [6:0] {
      tlp_mrd32 = 7'b00_00000,
      tlp_mwr32 = 7'b10_00000,
      tlp_cpld  = 7'b10_01010
   } tlp_fmt_type_t;

   // header DW0, bit 31 first
   typedef struct packed {
      logic          rsvd_31;
      tlp_fmt_type_t fmt_type;
      logic          rsvd_23;
      logic [2:0]    tc;
      logic [3:0]    rsvd_19_16;
      logic          td;
      logic          ep;
      logic [1:0]    attr;
      logic [1:0]    at;
      logic [9:0]    length;
   } tlp_dw0_t;

   // what a read request needs to be answered
   typedef struct packed {
      logic [15:0] requester_id;
      logic [7:0]  tag;
      logic [6:0]  lower_addr;
   } req_info_t;

   // completion DW1
   typedef struct packed {
      logic [15:0] completer_id;
      logic [2:0]  status;
      logic        bcm;
      logic [11:0] byte_count;
   } cpl_dw1_t;

endpackage

/* logic/hififo_pio_if.sv */
`timescale 1ns/1ps
`include "hififo_settings.svh"

// decoded register accesses from the rx parser
interface hififo_pio_if;
   logic                      write_valid;
   logic                      read_valid;
   logic [`HIFIFO_ADDR_W-1:0] address;
   logic [63:0]               data;
   hififo_pkg::req_info_t     info;

   modport parser
   (
      output write_valid,
      output read_valid,
      output address,
      output data,
      output info
   );

   modport regs
   (
      input write_valid,
      input read_valid,
      input address,
      input data,
      input info
   );
endinterface

/* logic/hififo_cpl_if.sv */
`timescale 1ns/1ps

// read results on their way to the completion builder
interface hififo_cpl_if;
   logic                  rc_done;
   logic [63:0]           rc_data;
   hififo_pkg::req_info_t rc_info;
   // queue full, pulses arriving now are dropped
   logic                  busy;

   modport regs
   (
      output rc_done,
      output rc_data,
      output rc_info
   );

   modport builder
   (
      input  rc_done,
      input  rc_data,
      input  rc_info,
      output busy
   );
endinterface

/* logic/pcie_rx.sv */
`timescale 1ns/1ps
`include "hififo_settings.svh"

module pcie_rx
(
   input  logic                clock,
   input  logic                rst_n,
   input  logic                tvalid,
   input  logic                tlast,
   input  logic [63:0]         tdata,
   hififo_pio_if.parser        pio
);

   // position inside the current TLP
   logic [1:0] beat;

   // DW0 of the TLP in flight
   hififo_pkg::tlp_dw0_t hdr_q;

   logic len_ok;
   logic write_ok;
   logic read_ok;

   assign len_ok = hdr_q.length == 10'd2;

   // write ends on beat 2, read on beat 1
   assign write_ok = (beat == 2'd2) && len_ok && (hdr_q.fmt_type == hififo_pkg::tlp_mwr32);
   assign read_ok  = (beat == 2'd1) && len_ok && (hdr_q.fmt_type == hififo_pkg::tlp_mrd32);

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         beat            <= 2'd0;
         pio.write_valid <= 1'b0;
         pio.read_valid  <= 1'b0;
      end
      else
      begin
         pio.write_valid <= tvalid && tlast && write_ok;
         pio.read_valid  <= tvalid && tlast && read_ok;
         if (tvalid)
         begin
            if (tlast)
            begin
               beat <= 2'd0;
            end
            else if (beat != 2'd3)
            begin
               // long TLPs park here until tlast
               beat <= beat + 2'd1;
            end
         end
      end
   end

   // header and payload capture
   always_ff @(posedge clock)
   begin
      if (tvalid)
      begin
         case (beat)
            2'd0:
            begin
               hdr_q                 <= hififo_pkg::tlp_dw0_t'(tdata[31:0]);
               pio.info.requester_id <= tdata[63:48];
               pio.info.tag          <= tdata[47:40];
            end
            2'd1:
            begin
               pio.address         <= tdata[`HIFIFO_ADDR_W+2:3];
               pio.info.lower_addr <= tdata[6:0];
               pio.data[31:0]      <= tdata[63:32];
            end
            2'd2:
            begin
               pio.data[63:32] <= tdata[31:0];
            end
            default:
            begin
               // trailing beats of ignored TLPs
            end
         endcase
      end
   end

endmodule

/* logic/hififo_regs.sv */
`timescale 1ns/1ps
`include "hififo_settings.svh"

module hififo_regs
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  logic [`HIFIFO_IRQ_W-1:0] events,
   output logic                     interrupt_out,
   hififo_pio_if.regs               pio,
   hififo_cpl_if.regs               cpl
);

   logic [63:0]               count;
   logic [63:0]               scratch;
   logic [`HIFIFO_IRQ_W-1:0]  mask;
   logic [`HIFIFO_IRQ_W-1:0]  status;
   logic [`HIFIFO_IRQ_W-1:0]  events_q;

   logic write_id;
   logic status_clear;

   assign write_id     = pio.write_valid && (pio.address == `HIFIFO_REG_ID);
   assign status_clear = pio.read_valid && (pio.address == `HIFIFO_REG_ID);

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         count         <= 64'd0;
         scratch       <= 64'd0;
         mask          <= '0;
         status        <= '0;
         events_q      <= '0;
         interrupt_out <= 1'b0;
         cpl.rc_done   <= 1'b0;
      end
      else
      begin
         count    <= count + 64'd1;
         events_q <= events;
         // edge on any enabled line, or a software kick
         interrupt_out <= (|(mask & (events ^ events_q))) || (write_id && pio.data[0]);
         status        <= status_clear ? '0 : (status | events);
         cpl.rc_done   <= pio.read_valid;
         if (pio.write_valid)
         begin
            if (pio.address == `HIFIFO_REG_SCRATCH)
            begin
               scratch <= pio.data;
            end
            if (pio.address == `HIFIFO_REG_MASK)
            begin
               mask <= pio.data[`HIFIFO_IRQ_W-1:0];
            end
         end
      end
   end

   // read data travels with the request info
   always_ff @(posedge clock)
   begin
      if (pio.read_valid)
      begin
         cpl.rc_info <= pio.info;
         case (pio.address)
            `HIFIFO_REG_ID:      cpl.rc_data <= `HIFIFO_ID;
            `HIFIFO_REG_COUNT:   cpl.rc_data <= count;
            `HIFIFO_REG_STATUS:  cpl.rc_data <= {{(64 - `HIFIFO_IRQ_W){1'b0}}, status};
            `HIFIFO_REG_SCRATCH: cpl.rc_data <= scratch;
            default:             cpl.rc_data <= 64'd0;
         endcase
      end
   end

endmodule

/* logic/pcie_tx.sv */
`timescale 1ns/1ps

module pcie_tx
(
   input  logic         clock,
   input  logic         rst_n,
   input  logic [15:0]  pci_id,
   hififo_cpl_if.builder cpl,
   input  logic         tready,
   output logic [63:0]  tdata,
   output logic         tvalid,
   output logic         tlast,
   output logic         one_dw
);

   typedef enum logic [1:0] {
      beat_hdr,
      beat_data,
      beat_last
   } beat_t;

   beat_t state;

   // two-entry completion queue
   logic [63:0]           q_data [2];
   hififo_pkg::req_info_t q_info [2];
   logic                  wr_ptr;
   logic                  rd_ptr;
   logic [1:0]            q_count;

   logic push;
   logic pop;

   hififo_pkg::tlp_dw0_t  cpl_dw0;
   hififo_pkg::cpl_dw1_t  cpl_dw1;
   logic [31:0]           cpl_dw2;
   logic [63:0]           head_data;
   hififo_pkg::req_info_t head_info;

   assign cpl.busy = q_count == 2'd2;
   assign push     = cpl.rc_done && !cpl.busy;
   assign pop      = tvalid && tready && (state == beat_last);

   assign head_data = q_data[rd_ptr];
   assign head_info = q_info[rd_ptr];

   always_ff @(posedge clock)
   begin
      if (push)
      begin
         q_data[wr_ptr] <= cpl.rc_data;
         q_info[wr_ptr] <= cpl.rc_info;
      end
   end

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         q_count <= 2'd0;
         state   <= beat_hdr;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop)
         begin
            rd_ptr <= ~rd_ptr;
         end
         q_count <= q_count + {1'b0, push} - {1'b0, pop};
         if (tvalid && tready)
         begin
            case (state)
               beat_hdr:  state <= beat_data;
               beat_data: state <= beat_last;
               default:   state <= beat_hdr;
            endcase
         end
      end
   end

   // completion header, always 2 DW and 8 bytes
   always_comb
   begin
      cpl_dw0          = '0;
      cpl_dw0.fmt_type = hififo_pkg::tlp_cpld;
      cpl_dw0.length   = 10'd2;
      cpl_dw1.completer_id = pci_id;
      cpl_dw1.status       = 3'b000;
      cpl_dw1.bcm          = 1'b0;
      cpl_dw1.byte_count   = 12'd8;
      cpl_dw2 = {head_info.requester_id, head_info.tag, 1'b0, head_info.lower_addr};
   end

   assign tvalid = q_count != 2'd0;
   assign tlast  = state == beat_last;
   assign one_dw = state == beat_last;

   always_comb
   begin
      case (state)
         beat_hdr:  tdata = {cpl_dw1, cpl_dw0};
         beat_data: tdata = {head_data[31:0], cpl_dw2};
         default:   tdata = {32'd0, head_data[63:32]};
      endcase
   end

endmodule

/* logic/hififo_pcie.sv */
`timescale 1ns/1ps
`include "hififo_settings.svh"

module hififo_pcie
(
   input  logic                     clock,
   input  logic                     rst_n,
   input  logic [15:0]              pci_id,
   // rx stream from the hard core
   input  logic                     rx_tvalid,
   input  logic                     rx_tlast,
   input  logic [63:0]              rx_tdata,
   // tx stream to the hard core
   input  logic                     tx_tready,
   output logic [63:0]              tx_tdata,
   output logic                     tx_tvalid,
   output logic                     tx_tlast,
   output logic                     tx_1dw,
   // events and interrupt
   input  logic [`HIFIFO_IRQ_W-1:0] irq_events,
   output logic                     interrupt_out
);

   hififo_pio_if pio();
   hififo_cpl_if cpl();

   pcie_rx rx
   (
      .clock  (clock),
      .rst_n  (rst_n),
      .tvalid (rx_tvalid),
      .tlast  (rx_tlast),
      .tdata  (rx_tdata),
      .pio    (pio.parser)
   );

   hififo_regs regs
   (
      .clock         (clock),
      .rst_n         (rst_n),
      .events        (irq_events),
      .interrupt_out (interrupt_out),
      .pio           (pio.regs),
      .cpl           (cpl.regs)
   );

   pcie_tx tx
   (
      .clock  (clock),
      .rst_n  (rst_n),
      .pci_id (pci_id),
      .cpl    (cpl.builder),
      .tready (tx_tready),
      .tdata  (tx_tdata),
      .tvalid (tx_tvalid),
      .tlast  (tx_tlast),
      .one_dw (tx_1dw)
   );

endmodule

/* dv/hififo_asserts.sv */
`timescale 1ns/1ps

module hififo_asserts
(
   input logic        clock,
   input logic        rst_n,
   input logic [63:0] tx_tdata,
   input logic        tx_tvalid,
   input logic        tx_tready,
   input logic        tx_tlast,
   input logic        tx_1dw,
   input logic        interrupt_out,
   input logic        rc_done,
   input logic        busy
);

   int failures = 0;

   // position of the current beat inside its completion
   logic [1:0] tx_beat;

   always_ff @(posedge clock or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tx_beat <= 2'd0;
      end
      else if (tx_tvalid && tx_tready)
      begin
         tx_beat <= tx_tlast ? 2'd0 : tx_beat + 2'd1;
      end
   end

   // a stalled beat stays put
   stalled_beat_holds: assert property (@(posedge clock) disable iff (!rst_n)
      tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast))
   else
   begin
      $error("tx beat changed while tready was low");
      failures++;
   end

   // tlast and 1dw together, on the third beat only
   one_dw_on_last: assert property (@(posedge clock) disable iff (!rst_n)
      tx_tvalid |-> (tx_tlast == (tx_beat == 2'd2)) && (tx_1dw == (tx_beat == 2'd2)))
   else
   begin
      $error("tlast or tx_1dw not on the third beat of a completion");
      failures++;
   end

   interrupt_single_cycle: assert property (@(posedge clock) disable iff (!rst_n)
      interrupt_out |=> !interrupt_out)
   else
   begin
      $error("interrupt_out high for two cycles");
      failures++;
   end

   // queue full drops the read result
   no_lost_completion: assert property (@(posedge clock) disable iff (!rst_n)
      !(rc_done && busy))
   else
   begin
      $error("completion arrived while the queue was full");
      failures++;
   end

endmodule

bind hififo_pcie hififo_asserts asserts
(
   .clock         (clock),
   .rst_n         (rst_n),
   .tx_tdata      (tx_tdata),
   .tx_tvalid     (tx_tvalid),
   .tx_tready     (tx_tready),
   .tx_tlast      (tx_tlast),
   .tx_1dw        (tx_1dw),
   .interrupt_out (interrupt_out),
   .rc_done       (cpl.rc_done),
   .busy          (cpl.busy)
);

/* dv/hififo_tb.sv */
`timescale 1ns/1ps
`include "hififo_settings.svh"

module hififo_tb;

   logic                     clock;
   logic                     rst_n;
   logic [15:0]              pci_id;
   logic                     rx_tvalid;
   logic                     rx_tlast;
   logic [63:0]              rx_tdata;
   logic                     tx_tready;
   logic [63:0]              tx_tdata;
   logic                     tx_tvalid;
   logic                     tx_tlast;
   logic                     tx_1dw;
   logic [`HIFIFO_IRQ_W-1:0] irq_events;
   logic                     interrupt_out;

   logic [31:0] rng;
   int          errors = 0;
   int          checks = 0;
   int          tests = 0;
   int          test_start;
   int          cycle_count = 0;
   int          read_cycle;
   string       test_name;
   bit          stall;

   // register model
   logic [63:0]              scratch_model;
   logic [`HIFIFO_IRQ_W-1:0] mask_model;
   logic [`HIFIFO_IRQ_W-1:0] status_model;

   hififo_pcie UUT
   (
      .clock         (clock),
      .rst_n         (rst_n),
      .pci_id        (pci_id),
      .rx_tvalid     (rx_tvalid),
      .rx_tlast      (rx_tlast),
      .rx_tdata      (rx_tdata),
      .tx_tready     (tx_tready),
      .tx_tdata      (tx_tdata),
      .tx_tvalid     (tx_tvalid),
      .tx_tlast      (tx_tlast),
      .tx_1dw        (tx_1dw),
      .irq_events    (irq_events),
      .interrupt_out (interrupt_out)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   always @(posedge clock)
   begin
      cycle_count <= cycle_count + 1;
   end

   // xorshift32
   function automatic logic [31:0] next_random();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   function automatic logic [31:0] make_dw0(input hififo_pkg::tlp_fmt_type_t kind,
                                            input logic [9:0] len);
      hififo_pkg::tlp_dw0_t dw0;
      dw0          = '0;
      dw0.fmt_type = kind;
      dw0.length   = len;
      return dw0;
   endfunction

   task automatic next_cycle();
      @(posedge clock);
      #2;
   endtask

   task automatic check_value(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      assert (actual == expected)
      else
      begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic finish_test();
      tests++;
      $display("test %s finished with %0d errors", test_name, errors - test_start);
   endtask

   task automatic send_tlp(input logic [63:0] b0, input logic [63:0] b1,
                           input logic [63:0] b2, input logic [1:0] n);
      logic [63:0] words [3];
      logic [1:0]  i;
      words[0] = b0;
      words[1] = b1;
      words[2] = b2;
      for (i = 2'd0; i < n; i++)
      begin
         rx_tvalid = 1'b1;
         rx_tdata  = words[i];
         rx_tlast  = (i == n - 2'd1);
         if (rx_tlast)
         begin
            read_cycle = cycle_count;
         end
         next_cycle();
      end
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
   endtask

   task automatic write_reg(input logic [12:0] addr, input logic [63:0] data);
      logic [31:0] r;
      logic [31:0] dw2;
      r   = next_random();
      dw2 = {16'd0, addr, 3'b000};
      send_tlp({r[31:16], r[7:0], 8'hff, make_dw0(hififo_pkg::tlp_mwr32, 10'd2)},
               {data[31:0], dw2}, {32'd0, data[63:32]}, 2'd3);
   endtask

   // one read, then its whole completion, checked beat by beat
   task automatic read_reg(input logic [12:0] addr, output logic [63:0] data);
      logic [31:0]          r;
      logic [31:0]          dw2;
      logic [15:0]          req_id;
      logic [7:0]           tag;
      logic [63:0]          beats [3];
      logic [2:0]           lasts;
      logic [2:0]           ones;
      logic [1:0]           got;
      hififo_pkg::cpl_dw1_t exp_dw1;
      int                   waited;
      r      = next_random();
      req_id = r[31:16];
      tag    = r[7:0];
      dw2    = {16'd0, addr, 3'b000};
      send_tlp({req_id, tag, 8'hff, make_dw0(hififo_pkg::tlp_mrd32, 10'd2)},
               {32'd0, dw2}, 64'd0, 2'd2);
      if (addr == `HIFIFO_REG_ID)
      begin
         status_model = irq_events;
      end
      got    = 2'd0;
      waited = 0;
      while (got != 2'd3 && waited < 200)
      begin
         if (stall)
         begin
            r         = next_random();
            tx_tready = (r[1:0] != 2'b00);
         end
         @(negedge clock);
         if (tx_tvalid && tx_tready)
         begin
            beats[got] = tx_tdata;
            lasts[got] = tx_tlast;
            ones[got]  = tx_1dw;
            got++;
         end
         next_cycle();
         waited++;
      end
      tx_tready = 1'b1;
      data      = 64'd0;
      if (got != 2'd3)
      begin
         $display("%s: no complete completion for register %0d within 200 cycles",
                  test_name, addr);
         errors++;
      end
      else
      begin
         exp_dw1              = '0;
         exp_dw1.completer_id = pci_id;
         exp_dw1.byte_count   = 12'd8;
         check_value("completion DW1/DW0", {exp_dw1, make_dw0(hififo_pkg::tlp_cpld, 10'd2)},
                     beats[0]);
         check_value("completion DW2", 64'({req_id, tag, 1'b0, dw2[6:0]}),
                     64'(beats[1][31:0]));
         check_value("tlast per beat", 64'(3'b100), 64'(lasts));
         check_value("1dw per beat", 64'(3'b100), 64'(ones));
         data = {beats[2][31:0], beats[1][63:32]};
      end
   endtask

   task automatic count_pulses(output int pulses);
      pulses = 0;
      repeat (4)
      begin
         next_cycle();
         if (interrupt_out)
         begin
            pulses++;
         end
      end
   endtask

   // nothing may leave the tx port for a while
   task automatic expect_quiet();
      logic seen;
      seen = 1'b0;
      repeat (20)
      begin
         next_cycle();
         seen = seen | tx_tvalid;
      end
      check_value("tx_tvalid while idle", 64'd0, 64'(seen));
   endtask

   task automatic run_scratch_and_counter();
      logic [63:0] d;
      logic [63:0] first;
      logic [31:0] r;
      logic [12:0] addr;
      int          c1;
      test_name  = "scratch";
      test_start = errors;
      repeat (6)
      begin
         scratch_model = {next_random(), 32'd0};
         scratch_model[31:0] = next_random();
         write_reg(`HIFIFO_REG_SCRATCH, scratch_model);
         read_reg(`HIFIFO_REG_SCRATCH, d);
         check_value("register 3", scratch_model, d);
      end
      repeat (4)
      begin
         r    = next_random();
         addr = {1'b1, r[11:0]};
         write_reg(addr, {r, ~r});
         read_reg(`HIFIFO_REG_SCRATCH, d);
         check_value("register 3 after unused write", scratch_model, d);
         read_reg(addr, d);
         check_value("unused register", 64'd0, d);
      end
      finish_test();
      test_name  = "counter";
      test_start = errors;
      repeat (4)
      begin
         read_reg(`HIFIFO_REG_COUNT, first);
         c1 = read_cycle;
         r  = next_random();
         repeat (r[3:0])
         begin
            next_cycle();
         end
         read_reg(`HIFIFO_REG_COUNT, d);
         check_value("counter increases", 64'd1, 64'(d > first));
         check_value("counter step covers gap", 64'd1, 64'((d - first) >= 64'(read_cycle - c1)));
      end
      finish_test();
   endtask

   task automatic run_interrupts();
      logic [63:0]              d;
      logic [31:0]              r;
      logic [`HIFIFO_IRQ_W-1:0] toggles;
      int                       pulses;
      test_name  = "interrupts";
      test_start = errors;
      repeat (2)
      begin
         r = next_random();
         write_reg(`HIFIFO_REG_MASK, {32'd0, r});
         mask_model = r[`HIFIFO_IRQ_W-1:0];
         // the new mask is in place one cycle after the write strobe
         next_cycle();
         repeat (8)
         begin
            r            = next_random();
            toggles      = r[`HIFIFO_IRQ_W-1:0];
            irq_events   = irq_events ^ toggles;
            status_model = status_model | irq_events;
            count_pulses(pulses);
            check_value("pulses after toggle", 64'((toggles & mask_model) != '0), 64'(pulses));
         end
         read_reg(`HIFIFO_REG_STATUS, d);
         check_value("status", 64'(status_model), d);
         read_reg(`HIFIFO_REG_ID, d);
         read_reg(`HIFIFO_REG_STATUS, d);
         check_value("status after clear", 64'(status_model), d);
      end
      write_reg(`HIFIFO_REG_ID, 64'd1);
      count_pulses(pulses);
      check_value("pulses after forced interrupt", 64'd1, 64'(pulses));
      write_reg(`HIFIFO_REG_ID, 64'd2);
      count_pulses(pulses);
      check_value("pulses after write without bit 0", 64'd0, 64'(pulses));
      finish_test();
   endtask

   task automatic run_backpressure_and_filter();
      logic [63:0] d;
      logic [31:0] r;
      test_name  = "backpressure";
      test_start = errors;
      stall      = 1'b1;
      repeat (10)
      begin
         r = next_random();
         if (r[0])
         begin
            scratch_model = {r, next_random()};
            write_reg(`HIFIFO_REG_SCRATCH, scratch_model);
            read_reg(`HIFIFO_REG_SCRATCH, d);
            check_value("register 3", scratch_model, d);
         end
         else
         begin
            read_reg(`HIFIFO_REG_ID, d);
            check_value("register 0", `HIFIFO_ID, d);
         end
      end
      stall = 1'b0;
      finish_test();
      test_name  = "filtering";
      test_start = errors;
      r = next_random();
      // 1-DW read, host completion, 1-DW write
      send_tlp({r, make_dw0(hififo_pkg::tlp_mrd32, 10'd1)}, {32'd0, 32'h18}, 64'd0, 2'd2);
      expect_quiet();
      send_tlp({r, make_dw0(hififo_pkg::tlp_cpld, 10'd2)}, {r, r}, {r, r}, 2'd3);
      expect_quiet();
      send_tlp({r, make_dw0(hififo_pkg::tlp_mwr32, 10'd1)}, {r, 32'h18}, 64'd0, 2'd2);
      expect_quiet();
      read_reg(`HIFIFO_REG_SCRATCH, d);
      check_value("register 3 after 1-DW write", scratch_model, d);
      finish_test();
   endtask

   initial
   begin
      logic [63:0] d;
      rst_n         = 1'b0;
      pci_id        = 16'h0300;
      rx_tvalid     = 1'b0;
      rx_tlast      = 1'b0;
      rx_tdata      = 64'd0;
      tx_tready     = 1'b1;
      irq_events    = '0;
      rng           = 32'h5b33_2fa0;
      stall         = 1'b0;
      scratch_model = 64'd0;
      mask_model    = '0;
      status_model  = '0;
      repeat (5)
      begin
         @(posedge clock);
      end
      #2;
      rst_n      = 1'b1;
      test_name  = "reset";
      test_start = errors;
      check_value("tx_tvalid", 64'd0, 64'(tx_tvalid));
      check_value("interrupt_out", 64'd0, 64'(interrupt_out));
      finish_test();
      test_name  = "identifier";
      test_start = errors;
      repeat (4)
      begin
         read_reg(`HIFIFO_REG_ID, d);
         check_value("register 0", `HIFIFO_ID, d);
      end
      finish_test();
      run_scratch_and_counter();
      run_interrupts();
      run_backpressure_and_filter();
      errors = errors + UUT.asserts.failures;
      $display("tests %0d, checks %0d, errors %0d (assertion failures %0d)",
               tests, checks, errors, UUT.asserts.failures);
      if (errors == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+include
logic/hififo_pkg.sv
logic/hififo_pio_if.sv
logic/hififo_cpl_if.sv
logic/pcie_rx.sv
logic/hififo_regs.sv
logic/pcie_tx.sv
logic/hififo_pcie.sv
dv/hififo_asserts.sv
dv/hififo_tb.sv

/* Makefile */
# Verilator simulation of the PCIe register endpoint

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module hififo_tb -f filelist.f \
		-Mdir obj_dir -o hififo_sim

run: compile
	@out="$$(./obj_dir/hififo_sim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
